//--- Bender.yml
package:
  name: periph

sources:
  - design/periph_pkg.sv
  - design/periph_interconnect.sv
  - design/gpio.sv
  - design/timer.sv
  - design/sram.sv
  - design/periph_top.sv
  - target: test
    files:
      - tests/periph_checker.sv
      - tests/periph_tb.sv

//--- design/gpio.sv
//############################################################
// gpio slave
// one 2-bit mode per pin in the control register, data
// register driven by the bus or sampled from input pins
//############################################################
`timescale 1ns/100ps
`default_nettype none

module gpio
    import periph_pkg::*;
#(
    parameter int GPIO_PINS = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sel_i,
    input  bus_req_t             bus_i,
    output logic                 data_ok_o,
    output bus_rsp_t             rsp_o,
    input  logic [GPIO_PINS-1:0] io_pin_i,
    output logic [GPIO_PINS-1:0] io_pin_o,
    output logic [GPIO_PINS-1:0] io_oe_o
);

    // two mode bits per pin
    logic [2*GPIO_PINS-1:0] ctrl_q;
    logic [GPIO_PINS-1:0]   data_q;
    logic [GPIO_PINS-1:0]   pin_in;
    logic                   wr_ctrl;
    logic                   wr_data;
    logic [31:0]            rdata_q;
    logic                   data_ok_q;

    assign wr_ctrl = sel_i & bus_i.we & (bus_i.addr[3:0] == GPIO_CTRL[3:0]);
    assign wr_data = sel_i & bus_i.we & (bus_i.addr[3:0] == GPIO_DATA[3:0]);

    // per-pin mode decode, reserved mode falls into neither
    always_comb begin
        for (int i = 0; i < GPIO_PINS; i++) begin
            io_oe_o[i] = (gpio_mode_e'(ctrl_q[2*i +: 2]) == GPIO_OUT);
            pin_in[i]  = (gpio_mode_e'(ctrl_q[2*i +: 2]) == GPIO_IN);
        end
    end

    assign io_pin_o = data_q;

    // control register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // all pins hi-z
            ctrl_q <= '0;
        end else if (wr_ctrl) begin
            ctrl_q <= bus_i.wdata[2*GPIO_PINS-1:0];
        end
    end

    // data register, input pins sampled every cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q <= '0;
        end else begin
            for (int i = 0; i < GPIO_PINS; i++) begin
                if (pin_in[i]) begin
                    // bus writes ignored on input pins
                    data_q[i] <= io_pin_i[i];
                end else if (wr_data) begin
                    data_q[i] <= bus_i.wdata[i];
                end
            end
        end
    end

    // registered read and handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q   <= '0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= sel_i;
            if (sel_i && !bus_i.we) begin
                case (bus_i.addr[3:0])
                    GPIO_CTRL[3:0]: rdata_q <= 32'(ctrl_q);
                    GPIO_DATA[3:0]: rdata_q <= 32'(data_q);
                    default:        rdata_q <= '0;
                endcase
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign data_ok_o   = data_ok_q;
    assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

//--- design/periph_interconnect.sv
//############################################################
// peripheral bus interconnect
// round-robin arbiter for two masters, address decoder
// and return path of data_ok and read data to the owner
//############################################################
`timescale 1ns/100ps
`default_nettype none

module periph_interconnect
    import periph_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // master 0, core data port
    input  logic     m0_req_i,
    input  bus_req_t m0_bus_i,
    output logic     m0_addr_ok_o,
    output logic     m0_data_ok_o,
    output bus_rsp_t m0_rsp_o,
    // master 1, debug port
    input  logic     m1_req_i,
    input  bus_req_t m1_bus_i,
    output logic     m1_addr_ok_o,
    output logic     m1_data_ok_o,
    output bus_rsp_t m1_rsp_o,
    // slave side
    output bus_req_t slv_bus_o,
    output logic     sram_sel_o,
    output logic     timer_sel_o,
    output logic     gpio_sel_o,
    input  logic     sram_data_ok_i,
    input  logic     timer_data_ok_i,
    input  logic     gpio_data_ok_i,
    input  bus_rsp_t sram_rsp_i,
    input  bus_rsp_t timer_rsp_i,
    input  bus_rsp_t gpio_rsp_i
);

    // set when master 1 won the last arbitration
    logic        last_m1_q;
    logic        gnt_m0;
    logic        gnt_m1;
    logic        gnt_any;
    slave_sel_e  sel_d;
    slave_sel_e  sel_q;
    owner_e      owner_q;
    logic        rsp_ok;
    logic [31:0] rsp_data;

    // m0 wins unless m1 also asks and m0 had the last turn
    assign gnt_m0  = m0_req_i & (~m1_req_i | last_m1_q);
    assign gnt_m1  = m1_req_i & ~gnt_m0;
    assign gnt_any = gnt_m0 | gnt_m1;

    // address phase, combinational accept
    assign m0_addr_ok_o = gnt_m0;
    assign m1_addr_ok_o = gnt_m1;

    assign slv_bus_o = gnt_m1 ? m1_bus_i : m0_bus_i;
    assign sel_d     = decode_sel(slv_bus_o.addr);

    // one-hot strobe to the addressed slave
    assign sram_sel_o  = gnt_any & (sel_d == SEL_SRAM);
    assign timer_sel_o = gnt_any & (sel_d == SEL_TIMER);
    assign gpio_sel_o  = gnt_any & (sel_d == SEL_GPIO);

    // owner and target of the data phase one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // so master 0 gets the first contended grant
            last_m1_q <= 1'b1;
            owner_q   <= OWN_IDLE;
            sel_q     <= SEL_NONE;
        end else begin
            if (gnt_any) begin
                last_m1_q <= gnt_m1;
            end
            if (gnt_m0) begin
                owner_q <= OWN_M0;
            end else if (gnt_m1) begin
                owner_q <= OWN_M1;
            end else begin
                owner_q <= OWN_IDLE;
            end
            sel_q <= sel_d;
        end
    end

    // response from the slave picked in the address phase
    always_comb begin
        unique case (sel_q)
            SEL_SRAM: begin
                rsp_ok   = sram_data_ok_i;
                rsp_data = sram_rsp_i.rdata;
            end
            SEL_TIMER: begin
                rsp_ok   = timer_data_ok_i;
                rsp_data = timer_rsp_i.rdata;
            end
            SEL_GPIO: begin
                rsp_ok   = gpio_data_ok_i;
                rsp_data = gpio_rsp_i.rdata;
            end
            default: begin
                // unmapped, answered here with zero
                rsp_ok   = (owner_q != OWN_IDLE);
                rsp_data = '0;
            end
        endcase
    end

    assign m0_data_ok_o   = rsp_ok & (owner_q == OWN_M0);
    assign m1_data_ok_o   = rsp_ok & (owner_q == OWN_M1);
    // the other master sees zero
    assign m0_rsp_o.rdata = (owner_q == OWN_M0) ? rsp_data : '0;
    assign m1_rsp_o.rdata = (owner_q == OWN_M1) ? rsp_data : '0;

endmodule

`default_nettype wire

//--- design/periph_pkg.sv
//############################################################
// peripheral bus package
// request and response structs, target and owner enums,
// gpio pin modes and the fixed address map of the slaves
//############################################################
`default_nettype none

package periph_pkg;

    // one request as driven by a master and muxed to the slaves
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
        // byte lane write mask
        logic [3:0]  wem;
    } bus_req_t;

    // read data, valid with data_ok
    typedef struct packed {
        logic [31:0] rdata;
    } bus_rsp_t;

    // target slave, from addr[31:28]
    typedef enum logic [1:0] {
        SEL_SRAM,
        SEL_TIMER,
        SEL_GPIO,
        SEL_NONE
    } slave_sel_e;

    // which master receives the pending data phase
    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_M0,
        OWN_M1
    } owner_e;

    // pin mode, 3 is reserved and acts as hi-z
    typedef enum logic [1:0] {
        GPIO_HIZ = 2'd0,
        GPIO_OUT = 2'd1,
        GPIO_IN  = 2'd2
    } gpio_mode_e;

    // slave base addresses
    localparam logic [31:0] SRAM_BASE  = 32'h1000_0000;
    localparam logic [31:0] TIMER_BASE = 32'h2000_0000;
    localparam logic [31:0] GPIO_BASE  = 32'h3000_0000;

    // register offsets inside a slave
    localparam logic [31:0] GPIO_CTRL   = 32'h0;
    localparam logic [31:0] GPIO_DATA   = 32'h4;
    localparam logic [31:0] TIMER_CTRL  = 32'h0;
    localparam logic [31:0] TIMER_COUNT = 32'h4;
    localparam logic [31:0] TIMER_CMP   = 32'h8;

    // address decode on the top nibble
    function automatic slave_sel_e decode_sel(input logic [31:0] addr);
        if (addr[31:28] == SRAM_BASE[31:28]) begin
            return SEL_SRAM;
        end else if (addr[31:28] == TIMER_BASE[31:28]) begin
            return SEL_TIMER;
        end else if (addr[31:28] == GPIO_BASE[31:28]) begin
            return SEL_GPIO;
        end
        return SEL_NONE;
    endfunction

endpackage

`default_nettype wire

//--- design/periph_top.sv
//############################################################
// peripheral subsystem top
// two bus masters, the interconnect, sram, timer and gpio
//############################################################
`timescale 1ns/100ps
`default_nettype none

module periph_top
    import periph_pkg::*;
#(
    parameter int SRAM_WORDS = 256,
    parameter int GPIO_PINS  = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 m0_req_i,
    input  bus_req_t             m0_bus_i,
    output logic                 m0_addr_ok_o,
    output logic                 m0_data_ok_o,
    output bus_rsp_t             m0_rsp_o,
    input  logic                 m1_req_i,
    input  bus_req_t             m1_bus_i,
    output logic                 m1_addr_ok_o,
    output logic                 m1_data_ok_o,
    output bus_rsp_t             m1_rsp_o,
    input  logic [GPIO_PINS-1:0] gpio_pin_i,
    output logic [GPIO_PINS-1:0] gpio_pin_o,
    output logic [GPIO_PINS-1:0] gpio_oe_o,
    output logic                 timer_irq_o
);

    // shared slave request bus
    bus_req_t slv_bus;
    logic     sram_sel;
    logic     timer_sel;
    logic     gpio_sel;
    logic     sram_data_ok;
    logic     timer_data_ok;
    logic     gpio_data_ok;
    bus_rsp_t sram_rsp;
    bus_rsp_t timer_rsp;
    bus_rsp_t gpio_rsp;

    periph_interconnect u_ic (
        .clk             (clk),
        .rst_n           (rst_n),
        .m0_req_i        (m0_req_i),
        .m0_bus_i        (m0_bus_i),
        .m0_addr_ok_o    (m0_addr_ok_o),
        .m0_data_ok_o    (m0_data_ok_o),
        .m0_rsp_o        (m0_rsp_o),
        .m1_req_i        (m1_req_i),
        .m1_bus_i        (m1_bus_i),
        .m1_addr_ok_o    (m1_addr_ok_o),
        .m1_data_ok_o    (m1_data_ok_o),
        .m1_rsp_o        (m1_rsp_o),
        .slv_bus_o       (slv_bus),
        .sram_sel_o      (sram_sel),
        .timer_sel_o     (timer_sel),
        .gpio_sel_o      (gpio_sel),
        .sram_data_ok_i  (sram_data_ok),
        .timer_data_ok_i (timer_data_ok),
        .gpio_data_ok_i  (gpio_data_ok),
        .sram_rsp_i      (sram_rsp),
        .timer_rsp_i     (timer_rsp),
        .gpio_rsp_i      (gpio_rsp)
    );

    sram #(.SRAM_WORDS(SRAM_WORDS)) u_sram (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel_i     (sram_sel),
        .bus_i     (slv_bus),
        .data_ok_o (sram_data_ok),
        .rsp_o     (sram_rsp)
    );

    timer u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .sel_i       (timer_sel),
        .bus_i       (slv_bus),
        .data_ok_o   (timer_data_ok),
        .rsp_o       (timer_rsp),
        .timer_irq_o (timer_irq_o)
    );

    gpio #(.GPIO_PINS(GPIO_PINS)) u_gpio (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel_i     (gpio_sel),
        .bus_i     (slv_bus),
        .data_ok_o (gpio_data_ok),
        .rsp_o     (gpio_rsp),
        .io_pin_i  (gpio_pin_i),
        .io_pin_o  (gpio_pin_o),
        .io_oe_o   (gpio_oe_o)
    );

endmodule

`default_nettype wire

//--- design/sram.sv
//############################################################
// sram slave
// single-port word memory, byte lanes written under the
// write mask, registered read
//############################################################
`timescale 1ns/100ps
`default_nettype none

module sram
    import periph_pkg::*;
#(
    parameter int SRAM_WORDS = 256
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     sel_i,
    input  bus_req_t bus_i,
    output logic     data_ok_o,
    output bus_rsp_t rsp_o
);

    localparam int AW = $clog2(SRAM_WORDS);

    logic [31:0]   mem [SRAM_WORDS];
    // word index above the byte offset
    logic [AW-1:0] idx;
    logic [31:0]   rdata_q;
    logic          data_ok_q;

    assign idx = bus_i.addr[AW+1:2];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (sel_i && bus_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_i.wem[b]) begin
                    mem[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // read port and handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q   <= '0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= sel_i;
            if (sel_i && !bus_i.we) begin
                rdata_q <= mem[idx];
            end else begin
                // zero outside read data phases
                rdata_q <= '0;
            end
        end
    end

    assign data_ok_o   = data_ok_q;
    assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

//--- design/timer.sv
//############################################################
// timer slave
// free-running 32-bit counter with compare register and a
// sticky interrupt raised on compare match
//############################################################
`timescale 1ns/100ps
`default_nettype none

module timer
    import periph_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     sel_i,
    input  bus_req_t bus_i,
    output logic     data_ok_o,
    output bus_rsp_t rsp_o,
    output logic     timer_irq_o
);

    logic        en_q;
    logic [31:0] count_q;
    logic [31:0] cmp_q;
    logic        irq_q;
    logic        wr;
    logic        match;
    logic [31:0] rdata_q;
    logic        data_ok_q;

    assign wr    = sel_i & bus_i.we;
    // only counts while enabled, so reset state never matches
    assign match = en_q & (count_q == cmp_q);

    // ctrl bit 0 enable, bit 1 clears irq and is not stored
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_q <= 1'b0;
        end else if (wr && bus_i.addr[3:0] == TIMER_CTRL[3:0]) begin
            en_q <= bus_i.wdata[0];
        end
    end

    // counter, a bus write overrides the increment
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (wr && bus_i.addr[3:0] == TIMER_COUNT[3:0]) begin
            count_q <= bus_i.wdata;
        end else if (en_q) begin
            count_q <= count_q + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmp_q <= '0;
        end else if (wr && bus_i.addr[3:0] == TIMER_CMP[3:0]) begin
            cmp_q <= bus_i.wdata;
        end
    end

    // sticky irq, a new match beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else if (match) begin
            irq_q <= 1'b1;
        end else if (wr && bus_i.addr[3:0] == TIMER_CTRL[3:0] && bus_i.wdata[1]) begin
            irq_q <= 1'b0;
        end
    end

    // registered read and handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q   <= '0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= sel_i;
            if (sel_i && !bus_i.we) begin
                case (bus_i.addr[3:0])
                    TIMER_CTRL[3:0]:  rdata_q <= {31'd0, en_q};
                    TIMER_COUNT[3:0]: rdata_q <= count_q;
                    TIMER_CMP[3:0]:   rdata_q <= cmp_q;
                    default:          rdata_q <= '0;
                endcase
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign data_ok_o   = data_ok_q;
    assign rsp_o.rdata = rdata_q;
    assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

//--- tests/periph_checker.sv
//############################################################
// interconnect bus checker
// assertions on the addr_ok and data_ok strobes of both
// master ports, bound into the interconnect
//############################################################
`timescale 1ns/100ps
`default_nettype none

module periph_checker (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic m0_req_i,
    input wire logic m1_req_i,
    input wire logic m0_addr_ok_i,
    input wire logic m1_addr_ok_i,
    input wire logic m0_data_ok_i,
    input wire logic m1_data_ok_i
);

    // count of failed assertions
    int fail_count = 0;

    // data phase exactly one cycle after the address phase
    m0_data_follows: assert property (@(posedge clk) disable iff (!rst_n)
        m0_data_ok_i == $past(m0_addr_ok_i))
        else begin
            $error("m0 data_ok not one cycle after addr_ok");
            fail_count++;
        end

    m1_data_follows: assert property (@(posedge clk) disable iff (!rst_n)
        m1_data_ok_i == $past(m1_addr_ok_i))
        else begin
            $error("m1 data_ok not one cycle after addr_ok");
            fail_count++;
        end

    // no grant without a request
    m0_grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        m0_addr_ok_i |-> m0_req_i)
        else begin
            $error("m0 addr_ok without req");
            fail_count++;
        end

    m1_grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        m1_addr_ok_i |-> m1_req_i)
        else begin
            $error("m1 addr_ok without req");
            fail_count++;
        end

    // one winner per cycle
    single_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(m0_addr_ok_i && m1_addr_ok_i))
        else begin
            $error("both masters granted in one cycle");
            fail_count++;
        end

endmodule

bind periph_interconnect periph_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .m0_req_i     (m0_req_i),
    .m1_req_i     (m1_req_i),
    .m0_addr_ok_i (m0_addr_ok_o),
    .m1_addr_ok_i (m1_addr_ok_o),
    .m0_data_ok_i (m0_data_ok_o),
    .m1_data_ok_i (m1_data_ok_o)
);

`default_nettype wire

//--- tests/periph_tb.sv
//############################################################
// peripheral subsystem testbench
// drives both bus masters from a stimulus table, checks
// sram, gpio, timer, arbitration and unmapped accesses
//############################################################
`timescale 1ns/100ps
`default_nettype none

module periph_tb
    import periph_pkg::*;
();

    localparam int SRAM_WORDS   = 256;
    localparam int GPIO_PINS    = 16;
    localparam int ADDR_TIMEOUT = 20;
    localparam int DATA_TIMEOUT = 4;
    localparam int IRQ_TIMEOUT  = 40;
    // row check kinds
    localparam logic [1:0] CHK_NONE  = 2'd0;
    localparam logic [1:0] CHK_RDATA = 2'd1;
    localparam logic [1:0] CHK_PINS  = 2'd2;
    // pins 0,4,8,12 out, 1,5,9,13 in, 2,6,.. hi-z, 3,7,.. reserved
    localparam logic [31:0] CTRL_MIX = 32'hc9c9_c9c9;
    localparam logic [31:0] DATA_W   = 32'ha5a5_5a5a;
    // one byte mask per partial write starting at the low nibble
    localparam logic [31:0] WEM_SEQ  = 32'h9a5c_8421;

    typedef struct packed {
        logic [1:0]  kind;
        logic        master;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wem;
        logic [15:0] pin;
        logic [31:0] exp;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    logic                 m0_req;
    bus_req_t             m0_bus;
    logic                 m0_addr_ok;
    logic                 m0_data_ok;
    bus_rsp_t             m0_rsp;
    logic                 m1_req;
    bus_req_t             m1_bus;
    logic                 m1_addr_ok;
    logic                 m1_data_ok;
    bus_rsp_t             m1_rsp;
    logic [GPIO_PINS-1:0] gpio_pin_in;
    logic [GPIO_PINS-1:0] gpio_pin_out;
    logic [GPIO_PINS-1:0] gpio_oe;
    logic                 timer_irq;

    int          err_count = 0;
    int          cycle_cnt = 0;
    logic [31:0] rng_state = 32'hc744;
    logic [31:0] sram_model [8];
    row_t        rows [$];
    string       names [$];

    periph_top #(
        .SRAM_WORDS (SRAM_WORDS),
        .GPIO_PINS  (GPIO_PINS)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .m0_req_i     (m0_req),
        .m0_bus_i     (m0_bus),
        .m0_addr_ok_o (m0_addr_ok),
        .m0_data_ok_o (m0_data_ok),
        .m0_rsp_o     (m0_rsp),
        .m1_req_i     (m1_req),
        .m1_bus_i     (m1_bus),
        .m1_addr_ok_o (m1_addr_ok),
        .m1_data_ok_o (m1_data_ok),
        .m1_rsp_o     (m1_rsp),
        .gpio_pin_i   (gpio_pin_in),
        .gpio_pin_o   (gpio_pin_out),
        .gpio_oe_o    (gpio_oe),
        .timer_irq_o  (timer_irq)
    );

    // 4 ns period
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // stop at the first failed bus assertion
    always @(posedge clk) begin
        if (UUT.u_ic.u_checker.fail_count != 0) begin
            $display("bus protocol assertion failed in the interconnect");
            $display("Finished with errors");
            $fatal(1, "assertion failed");
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // old bytes kept where the mask bit is low
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  wem);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (wem[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // one bit per pin whose 2-bit mode equals mode
    function automatic logic [15:0] mode_mask(input logic [31:0] ctrl, input logic [1:0] mode);
        logic [15:0] mask;
        mask = '0;
        for (int p = 0; p < GPIO_PINS; p++) begin
            mask[p] = (ctrl[2*p +: 2] == mode);
        end
        return mask;
    endfunction

    // input pins show the pin level and all others the written data
    function automatic logic [31:0] gpio_expect(input logic [31:0] wdata,
                                                input logic [15:0] pins,
                                                input logic [31:0] ctrl);
        logic [15:0] in_mask;
        in_mask = mode_mask(ctrl, GPIO_IN);
        return {16'd0, (wdata[15:0] & ~in_mask) | (pins & in_mask)};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            err_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        err_count++;
        $display("no response in time: %s", what);
        $display("Finished with errors");
        $fatal(1, "wait timed out");
    endtask

    task automatic drive_request(input int master, input logic req, input bus_req_t b);
        if (master == 0) begin
            m0_req = req;
            m0_bus = b;
        end else begin
            m1_req = req;
            m1_bus = b;
        end
    endtask

    // one transfer that returns read data and the cycle of acceptance
    task automatic bus_transfer(input int master, input logic we, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] wem,
                                output logic [31:0] rdata, output int acc_cycle);
        bus_req_t b;
        logic     ok;
        int       waited;
        b.addr  = addr;
        b.wdata = wdata;
        b.we    = we;
        b.wem   = wem;
        @(negedge clk);
        drive_request(master, 1'b1, b);
        ok     = 1'b0;
        waited = 0;
        // addr_ok is combinational and sampled mid low phase
        while (!ok) begin
            #1;
            ok = (master == 0) ? m0_addr_ok : m1_addr_ok;
            if (!ok) begin
                if (waited == ADDR_TIMEOUT) begin
                    stop_on_timeout($sformatf("addr_ok for master %0d", master));
                end
                waited++;
                @(negedge clk);
            end
        end
        acc_cycle = cycle_cnt;
        @(posedge clk);
        @(negedge clk);
        drive_request(master, 1'b0, b);
        ok     = 1'b0;
        waited = 0;
        while (!ok) begin
            #1;
            ok = (master == 0) ? m0_data_ok : m1_data_ok;
            if (!ok) begin
                if (waited == DATA_TIMEOUT) begin
                    stop_on_timeout($sformatf("data_ok for master %0d", master));
                end
                waited++;
                @(negedge clk);
            end
        end
        rdata = (master == 0) ? m0_rsp.rdata : m1_rsp.rdata;
    endtask

    // both masters request in the same cycle
    task automatic contend(input logic we, input logic [31:0] a0, input logic [31:0] d0,
                           input logic [31:0] a1, input logic [31:0] d1,
                           output logic [31:0] r0, output logic [31:0] r1,
                           output int c0, output int c1);
        fork
            bus_transfer(0, we, a0, d0, 4'hf, r0, c0);
            bus_transfer(1, we, a1, d1, 4'hf, r1, c1);
        join
    endtask

    task automatic add_row(input string name, input logic [1:0] kind, input logic master,
                           input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wem, input logic [15:0] pin,
                           input logic [31:0] exp);
        row_t r;
        r.kind   = kind;
        r.master = master;
        r.we     = we;
        r.addr   = addr;
        r.wdata  = wdata;
        r.wem    = wem;
        r.pin    = pin;
        r.exp    = exp;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic build_table();
        logic [31:0] w;
        logic [31:0] gpio_w;
        logic [15:0] oe_exp;
        logic [3:0]  wem;
        // full word writes with alternating masters
        for (int i = 0; i < 8; i++) begin
            w = next_random();
            sram_model[i] = w;
            add_row("sram full write", CHK_NONE, i[0], 1'b1, SRAM_BASE + 4*i, w, 4'hf, '0, '0);
        end
        // partial writes merge under the byte mask
        for (int i = 0; i < 8; i++) begin
            w   = next_random();
            wem = WEM_SEQ[4*i +: 4];
            sram_model[i] = merge_bytes(sram_model[i], w, wem);
            add_row("sram partial write", CHK_NONE, ~i[0], 1'b1, SRAM_BASE + 4*i, w, wem,
                    '0, '0);
        end
        for (int i = 0; i < 8; i++) begin
            add_row($sformatf("sram read word %0d", i), CHK_RDATA, i[0], 1'b0,
                    SRAM_BASE + 4*i, '0, 4'hf, '0, sram_model[i]);
        end
        // gpio output side
        gpio_w = gpio_expect(DATA_W, 16'h0, CTRL_MIX);
        oe_exp = mode_mask(CTRL_MIX, GPIO_OUT);
        add_row("gpio ctrl write", CHK_NONE, 1'b0, 1'b1, GPIO_BASE + GPIO_CTRL, CTRL_MIX,
                4'hf, 16'h0, '0);
        add_row("gpio oe and pin out", CHK_PINS, 1'b1, 1'b1, GPIO_BASE + GPIO_DATA, DATA_W,
                4'hf, 16'h0, {oe_exp, gpio_w[15:0]});
        add_row("gpio ctrl read", CHK_RDATA, 1'b0, 1'b0, GPIO_BASE + GPIO_CTRL, '0, 4'hf,
                16'h0, CTRL_MIX);
        // gpio input sampling
        add_row("gpio data pins low", CHK_RDATA, 1'b1, 1'b0, GPIO_BASE + GPIO_DATA, '0, 4'hf,
                16'h0, gpio_expect(DATA_W, 16'h0, CTRL_MIX));
        add_row("gpio data pins high", CHK_RDATA, 1'b0, 1'b0, GPIO_BASE + GPIO_DATA, '0, 4'hf,
                16'hffff, gpio_expect(DATA_W, 16'hffff, CTRL_MIX));
        add_row("gpio data pins mixed", CHK_RDATA, 1'b1, 1'b0, GPIO_BASE + GPIO_DATA, '0,
                4'hf, 16'h1234, gpio_expect(DATA_W, 16'h1234, CTRL_MIX));
        // unmapped address reads zero and writes go nowhere
        add_row("unmapped read", CHK_RDATA, 1'b0, 1'b0, 32'h4000_0000, '0, 4'hf, 16'h1234,
                '0);
        add_row("unmapped write", CHK_NONE, 1'b1, 1'b1, 32'h4000_0000, 32'hffff_ffff, 4'hf,
                16'h1234, '0);
        add_row("gpio ctrl after unmapped", CHK_RDATA, 1'b0, 1'b0, GPIO_BASE + GPIO_CTRL, '0,
                4'hf, 16'h1234, CTRL_MIX);
        add_row("sram after unmapped", CHK_RDATA, 1'b1, 1'b0, SRAM_BASE, '0, 4'hf, 16'h1234,
                sram_model[0]);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] w100;
        logic [31:0] w101;
        int          c0;
        int          c1;
        int          waited;
        row_t        row;
        clk         = 1'b0;
        rst_n       = 1'b0;
        m0_req      = 1'b0;
        m0_bus      = '0;
        m1_req      = 1'b0;
        m1_bus      = '0;
        gpio_pin_in = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // master 0 wins the first contention after reset
        w100 = next_random();
        w101 = next_random();
        contend(1'b1, SRAM_BASE + 400, w100, SRAM_BASE + 404, w101, r0, r1, c0, c1);
        check_value("arb m0 first after reset", 1, c0 < c1);
        bus_transfer(0, 1'b0, SRAM_BASE + 400, '0, 4'hf, rd, c0);
        check_value("arb solo read m0", w100, rd);
        // m0 had the last grant so m1 goes first now
        contend(1'b0, SRAM_BASE + 400, '0, SRAM_BASE + 404, '0, r0, r1, c0, c1);
        check_value("arb m1 first after m0 turn", 1, c1 < c0);
        check_value("arb read m0", w100, r0);
        check_value("arb read m1", w101, r1);

        build_table();
        for (int i = 0; i < rows.size(); i++) begin
            row = rows[i];
            @(negedge clk);
            gpio_pin_in = row.pin;
            // pin must settle two cycles before a read
            repeat (2) @(negedge clk);
            bus_transfer(row.master, row.we, row.addr, row.wdata, row.wem, rd, c0);
            if (row.kind == CHK_RDATA) begin
                check_value(names[i], row.exp, rd);
            end else if (row.kind == CHK_PINS) begin
                check_value(names[i], row.exp, {gpio_oe, gpio_pin_out});
            end
        end

        // timer compare at 20 from a cleared counter
        bus_transfer(0, 1'b1, TIMER_BASE + TIMER_CMP, 32'd20, 4'hf, rd, c0);
        bus_transfer(1, 1'b1, TIMER_BASE + TIMER_COUNT, 32'd0, 4'hf, rd, c0);
        bus_transfer(0, 1'b1, TIMER_BASE + TIMER_CTRL, 32'd1, 4'hf, rd, c0);
        check_value("timer irq low after enable", 0, timer_irq);
        waited = 0;
        while (!timer_irq) begin
            if (waited == IRQ_TIMEOUT) begin
                stop_on_timeout("timer_irq_o within 40 cycles");
            end
            waited++;
            @(negedge clk);
        end
        check_value("timer irq not before compare", 1, waited >= 20);
        bus_transfer(1, 1'b0, TIMER_BASE + TIMER_COUNT, '0, 4'hf, rd, c0);
        check_value("timer count past compare", 1, rd >= 32'd20);
        // clear bit also drops enable
        bus_transfer(0, 1'b1, TIMER_BASE + TIMER_CTRL, 32'd2, 4'hf, rd, c0);
        check_value("timer irq cleared", 0, timer_irq);

        if (err_count == 0 && UUT.u_ic.u_checker.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/periph_pkg.sv
design/periph_interconnect.sv
design/gpio.sv
design/timer.sv
design/sram.sv
design/periph_top.sv
tests/periph_checker.sv
tests/periph_tb.sv
